// ==== src/hk_pkg.sv ====
/*
 * Housekeeping SPI shared definitions
 * Widths, register map, reset values, fixed IDs, sequencer phases
 * and the bus and PLL configuration structs
 */
package hk_pkg;

    // ------------------------------------------------------------------------
    // Basic widths
    // ------------------------------------------------------------------------
    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  addr_t;
    typedef logic [2:0]  bitcnt_t;
    typedef logic [31:0] mask_rev_t;
    typedef logic [25:0] pll_trim_t;
    typedef logic [4:0]  pll_div_t;
    typedef logic [2:0]  pll_sel_t;

    // Sequencer phase within a CSB frame
    typedef enum logic [1:0] {
        ST_COMMAND = 2'b00,
        ST_ADDRESS = 2'b01,
        ST_DATA    = 2'b10
    } spi_state_e;

    // All PLL controls as seen by the clock generator
    typedef struct packed {
        logic      ena;
        logic      dco_ena;
        logic      bypass;
        pll_trim_t trim;
        pll_sel_t  sel;
        pll_sel_t  sel90;
        pll_div_t  div;
    } pll_cfg_t;

    // Register access from the serial target to the bank
    typedef struct packed {
        addr_t addr;
        byte_t wdata;
        logic  wrstb;
    } hk_bus_t;

    // ------------------------------------------------------------------------
    // Identification
    // ------------------------------------------------------------------------
    localparam logic [11:0] MFGR_ID = 12'h456;
    localparam byte_t       PROD_ID = 8'h10;

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam addr_t REG_STATUS     = 8'h00;
    localparam addr_t REG_MFGR_HI    = 8'h01;
    localparam addr_t REG_MFGR_LO    = 8'h02;
    localparam addr_t REG_PROD       = 8'h03;
    // Mask revision, most significant byte first
    localparam addr_t REG_MASK0      = 8'h04;
    localparam addr_t REG_MASK1      = 8'h05;
    localparam addr_t REG_MASK2      = 8'h06;
    localparam addr_t REG_MASK3      = 8'h07;
    localparam addr_t REG_PLL_ENA    = 8'h08;
    localparam addr_t REG_PLL_BYPASS = 8'h09;
    localparam addr_t REG_IRQ        = 8'h0A;
    localparam addr_t REG_RESET      = 8'h0B;
    localparam addr_t REG_TRAP       = 8'h0C;
    // Trim, least significant byte first
    localparam addr_t REG_TRIM0      = 8'h0D;
    localparam addr_t REG_TRIM1      = 8'h0E;
    localparam addr_t REG_TRIM2      = 8'h0F;
    localparam addr_t REG_TRIM3      = 8'h10;
    localparam addr_t REG_PLL_SEL    = 8'h11;
    localparam addr_t REG_PLL_DIV    = 8'h12;

    // PLL defaults: slow trim with bit 12 clear for a clean start,
    // divide-by-2 outputs, free-running DCO, PLL off and bypassed
    localparam pll_cfg_t PLL_CFG_RST = '{
        ena:     1'b0,
        dco_ena: 1'b1,
        bypass:  1'b1,
        trim:    26'h3FF_EFFF,
        sel:     3'd2,
        sel90:   3'd2,
        div:     5'd4
    };

endpackage

// ==== src/hk_spi_tx.sv ====
`timescale 1ns/1ps

/*
 * Housekeeping SPI falling-edge output stage
 * Loads and shifts readback data onto SDO, drives the SDO enable
 * and times the write strobe half a cycle ahead of the last data bit
 */
module hk_spi_tx
    import hk_pkg::*;
(
    input  logic       SCK,
    input  logic       RSTB,
    input  logic       CSB,
    input  logic       writemode,
    input  logic       readmode,
    input  spi_state_e state,
    input  bitcnt_t    count,
    input  byte_t      rdata,
    output logic       wrstb,
    output logic       SDO,
    output logic       sdo_enb
);

    logic  csb_rstb;
    // Outgoing byte, MSB presented on SDO
    byte_t ldata;

    assign csb_rstb = RSTB & ~CSB;
    assign SDO      = ldata[7];

    always_ff @(negedge SCK or negedge csb_rstb) begin
        if (!csb_rstb) begin
            wrstb   <= 1'b0;
            ldata   <= '0;
            sdo_enb <= 1'b1;
        end else if (state == ST_DATA) begin
            if (readmode) begin
                sdo_enb <= 1'b0;
                // Fresh byte at bit 0, then shift out MSB first
                if (count == 3'd0) begin
                    ldata <= rdata;
                end else begin
                    ldata <= {ldata[6:0], 1'b0};
                end
            end else begin
                sdo_enb <= 1'b1;
            end
            // Strobe up before the 8th data edge, so the
            // bank latches on that rising edge
            if (count == 3'd7) begin
                wrstb <= writemode;
            end else begin
                wrstb <= 1'b0;
            end
        end else begin
            // Command and address phases
            wrstb   <= 1'b0;
            sdo_enb <= 1'b1;
        end
    end

endmodule

// ==== src/hk_spi_slave.sv ====
`timescale 1ns/1ps

/*
 * Housekeeping SPI target sequencer
 * Shifts in command, address and data bytes on rising SCK and steps
 * the address; falling-edge output logic lives in hk_spi_tx
 */
module hk_spi_slave
    import hk_pkg::*;
(
    input  logic    SCK,
    input  logic    RSTB,
    input  logic    SDI,
    input  logic    CSB,
    input  byte_t   rdata,
    output hk_bus_t bus,
    output logic    SDO,
    output logic    sdo_enb
);

    // Frame reset, low while CSB is high or chip reset is active
    logic       csb_rstb;

    spi_state_e state;
    bitcnt_t    count;
    logic       writemode;
    logic       readmode;
    // Remaining bytes in fixed-count mode, zero means streaming
    logic [2:0] fixed_cnt;
    addr_t      addr;
    // Last seven SDI bits, upper part of the write byte
    logic [6:0] predata;
    logic       wrstb;

    assign csb_rstb = RSTB & ~CSB;

    // ------------------------------------------------------------------------
    // Rising-edge sequencer
    // ------------------------------------------------------------------------
    always_ff @(posedge SCK or negedge csb_rstb) begin
        if (!csb_rstb) begin
            state     <= ST_COMMAND;
            count     <= '0;
            writemode <= 1'b0;
            readmode  <= 1'b0;
            fixed_cnt <= '0;
            addr      <= '0;
        end else begin
            // Bit counter runs in every phase and wraps per byte
            count <= count + 3'd1;
            case (state)
                ST_COMMAND: begin
                    // Command byte, MSB first: W, R, three count bits
                    case (count)
                        3'd0: writemode <= SDI;
                        3'd1: readmode <= SDI;
                        3'd2, 3'd3, 3'd4: fixed_cnt <= {fixed_cnt[1:0], SDI};
                        // Bits 2..0 of the command are ignored
                        3'd7: state <= ST_ADDRESS;
                        default: ;
                    endcase
                end
                ST_ADDRESS: begin
                    addr <= {addr[6:0], SDI};
                    if (count == 3'd7) begin
                        state <= ST_DATA;
                    end
                end
                ST_DATA: begin
                    if (count == 3'd7) begin
                        // Byte done, step to next register
                        addr <= addr + 8'd1;
                        if (fixed_cnt == 3'd1) begin
                            // Last counted byte, next edge opens a command
                            state <= ST_COMMAND;
                        end else if (fixed_cnt != 3'd0) begin
                            fixed_cnt <= fixed_cnt - 3'd1;
                        end
                    end
                end
                default: begin
                    state <= ST_COMMAND;
                end
            endcase
        end
    end

    // Free-running input shifter
    // Only the seven bits before the last data edge are ever used
    always_ff @(posedge SCK) begin
        predata <= {predata[5:0], SDI};
    end

    // ------------------------------------------------------------------------
    // Falling-edge output side
    // ------------------------------------------------------------------------
    hk_spi_tx u_tx (
        .SCK       (SCK),
        .RSTB      (RSTB),
        .CSB       (CSB),
        .writemode (writemode),
        .readmode  (readmode),
        .state     (state),
        .count     (count),
        .rdata     (rdata),
        .wrstb     (wrstb),
        .SDO       (SDO),
        .sdo_enb   (sdo_enb)
    );

    // Write byte completes with the live SDI bit,
    // so the bank stores it on the last data edge
    assign bus = '{
        addr:  addr,
        wdata: {predata, SDI},
        wrstb: wrstb
    };

endmodule

// ==== src/hk_regs.sv ====
`timescale 1ns/1ps

/*
 * Housekeeping configuration register bank
 * PLL, IRQ and core-reset registers with byte writes by address,
 * plus combinational readback of IDs, mask revision and trap
 */
module hk_regs
    import hk_pkg::*;
(
    input  logic      SCK,
    input  logic      RSTB,
    input  hk_bus_t   bus,
    input  logic      trap,
    input  mask_rev_t mask_rev_in,
    output byte_t     rdata,
    output pll_cfg_t  pll,
    output logic      irq,
    output logic      reset
);

    // ------------------------------------------------------------------------
    // Write side
    // ------------------------------------------------------------------------
    always_ff @(posedge SCK or negedge RSTB) begin
        if (!RSTB) begin
            pll   <= PLL_CFG_RST;
            irq   <= 1'b0;
            reset <= 1'b0;
        end else if (bus.wrstb) begin
            // Only the bits that exist are kept
            case (bus.addr)
                REG_PLL_ENA: begin
                    pll.ena     <= bus.wdata[0];
                    pll.dco_ena <= bus.wdata[1];
                end
                REG_PLL_BYPASS: begin
                    pll.bypass <= bus.wdata[0];
                end
                REG_IRQ: begin
                    irq <= bus.wdata[0];
                end
                REG_RESET: begin
                    reset <= bus.wdata[0];
                end
                // Trim bytes, low byte at the lowest address
                REG_TRIM0: begin
                    pll.trim[7:0] <= bus.wdata;
                end
                REG_TRIM1: begin
                    pll.trim[15:8] <= bus.wdata;
                end
                REG_TRIM2: begin
                    pll.trim[23:16] <= bus.wdata;
                end
                REG_TRIM3: begin
                    pll.trim[25:24] <= bus.wdata[1:0];
                end
                REG_PLL_SEL: begin
                    pll.sel   <= bus.wdata[2:0];
                    pll.sel90 <= bus.wdata[5:3];
                end
                REG_PLL_DIV: begin
                    pll.div <= bus.wdata[4:0];
                end
                // IDs, mask rev, trap and unmapped: no effect
                default: ;
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Readback, zero-padded, zero for unmapped addresses
    // ------------------------------------------------------------------------
    always_comb begin
        rdata = '0;
        case (bus.addr)
            REG_STATUS:     rdata = 8'h00;
            REG_MFGR_HI:    rdata = {4'h0, MFGR_ID[11:8]};
            REG_MFGR_LO:    rdata = MFGR_ID[7:0];
            REG_PROD:       rdata = PROD_ID;
            // Metal-programmed revision, MSB byte first
            REG_MASK0:      rdata = mask_rev_in[31:24];
            REG_MASK1:      rdata = mask_rev_in[23:16];
            REG_MASK2:      rdata = mask_rev_in[15:8];
            REG_MASK3:      rdata = mask_rev_in[7:0];
            REG_PLL_ENA:    rdata = {6'b0, pll.dco_ena, pll.ena};
            REG_PLL_BYPASS: rdata = {7'b0, pll.bypass};
            REG_IRQ:        rdata = {7'b0, irq};
            REG_RESET:      rdata = {7'b0, reset};
            REG_TRAP:       rdata = {7'b0, trap};
            REG_TRIM0:      rdata = pll.trim[7:0];
            REG_TRIM1:      rdata = pll.trim[15:8];
            REG_TRIM2:      rdata = pll.trim[23:16];
            REG_TRIM3:      rdata = {6'b0, pll.trim[25:24]};
            REG_PLL_SEL:    rdata = {2'b0, pll.sel90, pll.sel};
            REG_PLL_DIV:    rdata = {3'b0, pll.div};
            default:        rdata = 8'h00;
        endcase
    end

endmodule

// ==== src/hk_spi_top.sv ====
`timescale 1ns/1ps

/*
 * Housekeeping SPI top level
 * Joins the serial target to the PLL, IRQ and reset register bank
 */
module hk_spi_top
    import hk_pkg::*;
(
    input  logic      SCK,
    input  logic      RSTB,
    input  logic      SDI,
    input  logic      CSB,
    input  logic      trap,
    input  mask_rev_t mask_rev_in,
    output logic      SDO,
    output logic      sdo_enb,
    output pll_cfg_t  pll,
    output logic      irq,
    output logic      reset
);

    // Register access and readback between target and bank
    hk_bus_t bus;
    byte_t   rdata;

    // Serial target
    hk_spi_slave u_slave (
        .SCK     (SCK),
        .RSTB    (RSTB),
        .SDI     (SDI),
        .CSB     (CSB),
        .rdata   (rdata),
        .bus     (bus),
        .SDO     (SDO),
        .sdo_enb (sdo_enb)
    );

    // Configuration registers
    hk_regs u_regs (
        .SCK         (SCK),
        .RSTB        (RSTB),
        .bus         (bus),
        .trap        (trap),
        .mask_rev_in (mask_rev_in),
        .rdata       (rdata),
        .pll         (pll),
        .irq         (irq),
        .reset       (reset)
    );

endmodule

// ==== verif/hk_clk_gen.sv ====
`timescale 1ns/1ps

/*
 * Testbench clock and reset source
 * Free-running 8 ns SCK, RSTB held low for the first 16 cycles
 */
module hk_clk_gen (
    output logic SCK,
    output logic RSTB
);

    // Half period of 4 ns
    initial begin
        SCK = 1'b0;
        forever #4 SCK = ~SCK;
    end

    // Release reset just after the 16th rising edge
    initial begin
        RSTB = 1'b0;
        repeat (16) @(posedge SCK);
        #1 RSTB = 1'b1;
    end

endmodule

// ==== verif/hk_spi_tb.sv ====
`timescale 1ns/1ps

/*
 * Housekeeping SPI testbench
 * Host-side serial driver, reference register model and checks
 * for reset values, writes, streaming, fixed count and output enable
 */
module hk_spi_tb
    import hk_pkg::*;
;

    logic      SCK;
    logic      RSTB;
    logic      SDI;
    logic      CSB;
    logic      trap;
    mask_rev_t mask_rev_in;
    logic      SDO;
    logic      sdo_enb;
    pll_cfg_t  pll;
    logic      irq;
    logic      reset;

    // Reference model of the writable registers
    logic       m_ena;
    logic       m_dco;
    logic       m_byp;
    logic [25:0] m_trim;
    logic [2:0] m_sel;
    logic [2:0] m_sel90;
    logic [4:0] m_div;
    logic       m_irq;
    logic       m_rst;

    // Data bytes of the next command
    byte_t wq[$];
    int    cycles;

    hk_clk_gen u_clk (
        .SCK  (SCK),
        .RSTB (RSTB)
    );

    hk_spi_top dut (
        .SCK         (SCK),
        .RSTB        (RSTB),
        .SDI         (SDI),
        .CSB         (CSB),
        .trap        (trap),
        .mask_rev_in (mask_rev_in),
        .SDO         (SDO),
        .sdo_enb     (sdo_enb),
        .pll         (pll),
        .irq         (irq),
        .reset       (reset)
    );

    // ------------------------------------------------------------------------
    // Failure reporting and comparison
    // ------------------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_equal(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        assert (got === exp) else
            stop_with_failure($sformatf("mismatch %s got 0x%0h expected 0x%0h",
                                        name, got, exp));
    endtask

    // Output enable must be off whenever the frame is closed
    assert property (@(posedge SCK) disable iff (!RSTB) CSB |-> sdo_enb) else
        stop_with_failure("mismatch sdo_enb got 0x0 expected 0x1 while CSB high");

    // Run limit well above the roughly 1600 cycles of frames
    always @(posedge SCK) begin
        cycles <= cycles + 1;
        if (cycles >= 4000) begin
            stop_with_failure("timeout: run exceeded 4000 SCK cycles");
        end
    end

    // ------------------------------------------------------------------------
    // Reference register model
    // ------------------------------------------------------------------------
    task automatic model_reset();
        m_ena   = 1'b0;
        m_dco   = 1'b1;
        m_byp   = 1'b1;
        // All ones except bit 12
        m_trim  = 26'h3FF_EFFF;
        m_sel   = 3'd2;
        m_sel90 = 3'd2;
        m_div   = 5'd4;
        m_irq   = 1'b0;
        m_rst   = 1'b0;
    endtask

    function automatic byte_t model_read(input addr_t a);
        case (a)
            8'h01: return 8'h04;
            8'h02: return 8'h56;
            8'h03: return 8'h10;
            8'h04: return mask_rev_in[31:24];
            8'h05: return mask_rev_in[23:16];
            8'h06: return mask_rev_in[15:8];
            8'h07: return mask_rev_in[7:0];
            8'h08: return {6'b0, m_dco, m_ena};
            8'h09: return {7'b0, m_byp};
            8'h0A: return {7'b0, m_irq};
            8'h0B: return {7'b0, m_rst};
            8'h0C: return {7'b0, trap};
            8'h0D: return m_trim[7:0];
            8'h0E: return m_trim[15:8];
            8'h0F: return m_trim[23:16];
            8'h10: return {6'b0, m_trim[25:24]};
            8'h11: return {2'b0, m_sel90, m_sel};
            8'h12: return {3'b0, m_div};
            // Status and unmapped read as zero
            default: return 8'h00;
        endcase
    endfunction

    task automatic model_write(input addr_t a, input byte_t d);
        case (a)
            8'h08: begin
                m_ena = d[0];
                m_dco = d[1];
            end
            8'h09: m_byp = d[0];
            8'h0A: m_irq = d[0];
            8'h0B: m_rst = d[0];
            8'h0D: m_trim[7:0] = d;
            8'h0E: m_trim[15:8] = d;
            8'h0F: m_trim[23:16] = d;
            8'h10: m_trim[25:24] = d[1:0];
            8'h11: begin
                m_sel   = d[2:0];
                m_sel90 = d[5:3];
            end
            8'h12: m_div = d[4:0];
            // Read-only and unmapped
            default: ;
        endcase
    endtask

    function automatic pll_cfg_t expected_pll();
        pll_cfg_t e;
        e.ena     = m_ena;
        e.dco_ena = m_dco;
        e.bypass  = m_byp;
        e.trim    = m_trim;
        e.sel     = m_sel;
        e.sel90   = m_sel90;
        e.div     = m_div;
        return e;
    endfunction

    task automatic check_ports();
        check_equal("pll", 64'(pll), 64'(expected_pll()));
        check_equal("irq", 64'(irq), 64'(m_irq));
        check_equal("reset", 64'(reset), 64'(m_rst));
    endtask

    // ------------------------------------------------------------------------
    // Host-side serial driver
    // ------------------------------------------------------------------------
    // One byte MSB first, SDO sampled at each rising edge
    task automatic shift_byte(input byte_t tx, input logic oe, output byte_t rx);
        for (int i = 7; i >= 0; i--) begin
            SDI = tx[i];
            @(posedge SCK);
            check_equal("sdo_enb", 64'(sdo_enb), 64'(!oe));
            rx[i] = SDO;
            #1;
        end
    endtask

    task automatic frame_begin();
        @(posedge SCK);
        #1 CSB = 1'b0;
    endtask

    task automatic frame_end();
        CSB = 1'b1;
        SDI = 1'b0;
        repeat (2) @(posedge SCK);
        #1;
    endtask

    // Command, address and the bytes in wq; reads checked against the model
    task automatic command(input byte_t cmd, input addr_t a);
        byte_t rx;
        byte_t exp_rd;
        addr_t cur;
        shift_byte(cmd, 1'b0, rx);
        shift_byte(a, 1'b0, rx);
        cur = a;
        foreach (wq[k]) begin
            // Old value is loaded before the same byte is written
            exp_rd = model_read(cur);
            shift_byte(wq[k], cmd[6], rx);
            if (cmd[6]) begin
                check_equal($sformatf("SDO byte at 0x%0h", cur), 64'(rx), 64'(exp_rd));
            end
            if (cmd[7]) begin
                model_write(cur, wq[k]);
            end
            cur = cur + 8'd1;
        end
    endtask

    task automatic xfer(input byte_t cmd, input addr_t a);
        frame_begin();
        command(cmd, a);
        frame_end();
    endtask

    task automatic fill_random(input int n);
        wq.delete();
        repeat (n) wq.push_back(byte_t'($urandom()));
    endtask

    task automatic fill_zero(input int n);
        wq.delete();
        repeat (n) wq.push_back(8'h00);
    endtask

    // ------------------------------------------------------------------------
    // Test sequence
    // ------------------------------------------------------------------------
    initial begin
        void'($urandom(72));
        cycles      = 0;
        CSB         = 1'b1;
        SDI         = 1'b0;
        trap        = 1'b1;
        mask_rev_in = $urandom();
        model_reset();
        wait (RSTB);

        // Reset values on the ports, then full map readback
        check_ports();
        check_equal("sdo_enb", 64'(sdo_enb), 64'h1);
        fill_zero(19);
        xfer(8'h40, 8'h00);

        // Single-byte write and readback over the whole map
        trap = 1'b0;
        for (int a = 0; a <= 18; a++) begin
            fill_random(1);
            xfer(8'h80, 8'(a));
            check_ports();
            fill_zero(1);
            xfer(8'h40, 8'(a));
        end

        // Streaming trim load and readback
        fill_random(4);
        xfer(8'h80, 8'h0D);
        check_ports();
        fill_zero(4);
        xfer(8'h40, 8'h0D);

        // Fixed count of 2, then a command with bit 0 set in the same frame
        wq = '{8'h00};
        xfer(8'h80, 8'h0B);
        frame_begin();
        wq = '{8'h00, 8'h01};
        command(8'h90, 8'h09);
        fill_random(1);
        command(8'h89, 8'h12);
        frame_end();
        check_ports();
        // Fixed read of one byte followed by a streaming read
        frame_begin();
        fill_zero(1);
        command(8'h48, 8'h12);
        fill_zero(2);
        command(8'h40, 8'h0A);
        frame_end();

        // Simultaneous read and write, then a no-op
        fill_random(5);
        xfer(8'hC0, 8'h08);
        check_ports();
        // Inverted bytes that would show on the ports if stored
        wq.delete();
        for (int a = 8'h0A; a <= 8'h0C; a++) begin
            wq.push_back(~model_read(8'(a)));
        end
        xfer(8'h00, 8'h0A);
        check_ports();

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

// ==== vlog.f ====
src/hk_pkg.sv
src/hk_spi_tx.sv
src/hk_spi_slave.sv
src/hk_regs.sv
src/hk_spi_top.sv
verif/hk_clk_gen.sv
verif/hk_spi_tb.sv

// ==== Makefile ====
SIM      := verilator
FLAGS    := --binary --timing --assert
TOP      := hk_spi_tb
FILELIST := vlog.f
PASS     := TESTBENCH PASSED

.PHONY: help build test clean

help:
	@echo "Targets:"
	@echo "  test   build with $(SIM) and run the testbench"
	@echo "  clean  remove build output"
	@echo "  help   show this list"

build:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

test: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS)"

clean:
	rm -rf obj_dir
